/* design/adcCapturePkg.sv */
`default_nettype none

package adcCapturePkg;

	// one conversion result and the channel address
	localparam int AdcDataW = 12;
	localparam int AdcChanW = 3;

	// divider setting, counts system clocks per half SCLK period
	localparam int AdcDivW = 8;

	// A minus B, one extra bit for the sign
	localparam int DiffW = AdcDataW + 1;

	// serial frame of 34 half-period ticks, 0 to 33
	localparam int FrameLastTick = 33;
	localparam int FrameCntW = 6;

	// ticks where SCLK rises and DOUT is captured
	localparam int FirstSampleTick = 10;
	localparam int LastSampleTick = 32;

endpackage : adcCapturePkg

`default_nettype wire

/* design/adcSerialCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module adcSerialCtrl (
	input  wire                                 Clk,
	input  wire                                 Rst_n,
	input  wire                                 En_Conv,
	input  wire [adcCapturePkg::AdcChanW-1:0]   Channel,
	input  wire [adcCapturePkg::AdcDivW-1:0]    DivParam,
	input  wire                                 Dout,
	output logic                                Sclk,
	output logic                                CsN,
	output logic                                Din,
	output logic [adcCapturePkg::AdcDataW-1:0]  Data,
	output logic                                Conv_Done,
	output wire                                 Busy
);

	import adcCapturePkg::*;

	logic                  runEn;     // high for the whole frame
	logic [AdcChanW-1:0]   chanReg;   // address latched at start
	logic [AdcDivW-1:0]    divCnt;
	logic                  tick;      // half SCLK period strobe
	logic [FrameCntW-1:0]  seqCnt;    // frame position
	logic [AdcDataW-1:0]   shiftReg;

	wire accept   = En_Conv & ~runEn;  // starts while running are dropped
	wire divLast  = (divCnt == DivParam - {{(AdcDivW-1){1'b0}}, 1'b1});
	wire frameEnd = runEn & tick & (seqCnt == FrameCntW'(FrameLastTick));
	wire sampleTick = ~seqCnt[0] &
		(seqCnt >= FrameCntW'(FirstSampleTick)) &
		(seqCnt <= FrameCntW'(LastSampleTick));

	always_ff @(posedge Clk) begin
		if (accept)
			chanReg <= Channel;
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			runEn <= 1'b0;
		end else if (accept) begin
			runEn <= 1'b1;
		end else if (frameEnd) begin
			runEn <= 1'b0;
		end
	end

	// divider, free running only while a frame is active
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			divCnt <= '0;
			tick <= 1'b0;
		end else begin
			if (!runEn || divLast)
				divCnt <= '0;
			else
				divCnt <= divCnt + 1'b1;
			tick <= runEn & divLast;
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			seqCnt <= '0;
		end else if (frameEnd) begin
			seqCnt <= '0;  // ready for the next start
		end else if (runEn && tick) begin
			seqCnt <= seqCnt + 1'b1;
		end
	end

	// serial pins follow the frame position
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			Sclk <= 1'b1;
			CsN <= 1'b1;
			Din <= 1'b1;
		end else if (!runEn) begin
			CsN <= 1'b1;
		end else if (tick) begin
			if (seqCnt == '0) begin
				CsN <= 1'b0;
			end else if (seqCnt == FrameCntW'(FrameLastTick)) begin
				CsN <= 1'b1;
				Din <= 1'b1;  // idle level between frames
			end else begin
				Sclk <= ~seqCnt[0];  // odd ticks fall, even ticks rise
				case (seqCnt)
					FrameCntW'(1): Din <= 1'b0;
					FrameCntW'(5): Din <= chanReg[2];  // addr msb
					FrameCntW'(7): Din <= chanReg[1];
					FrameCntW'(9): Din <= chanReg[0];
					default: Din <= Din;
				endcase
			end
		end
	end

	// result bits arrive msb first on the rising edges
	always_ff @(posedge Clk) begin
		if (runEn && tick && sampleTick)
			shiftReg <= {shiftReg[AdcDataW-2:0], Dout};
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			Data <= '0;
			Conv_Done <= 1'b0;
		end else begin
			Conv_Done <= frameEnd;
			if (frameEnd)
				Data <= shiftReg;
		end
	end

	assign Busy = runEn;

endmodule : adcSerialCtrl

`default_nettype wire

/* design/pairCombiner.sv */
`timescale 1ns/1ps
`default_nettype none

module pairCombiner (
	input  wire                                 Clk,
	input  wire                                 Rst_n,
	input  wire [adcCapturePkg::AdcDataW-1:0]   InA,
	input  wire [adcCapturePkg::AdcDataW-1:0]   InB,
	input  wire                                 DoneA,
	input  wire                                 DoneB,
	input  wire [adcCapturePkg::AdcDataW-1:0]   DiffLimit,
	output logic [adcCapturePkg::AdcDataW-1:0]  DataA,
	output logic [adcCapturePkg::AdcDataW-1:0]  DataB,
	output logic [adcCapturePkg::DiffW-1:0]     Diff,
	output logic                                Alarm,
	output logic                                SampleValid
);

	import adcCapturePkg::*;

	logic                 seenA;
	logic                 seenB;

	// a Done in this cycle counts as seen, keeps latency at one cycle
	// each controller holds its Data until its next Done
	wire                 bothSeen = (seenA | DoneA) & (seenB | DoneB);
	wire [DiffW-1:0]     diffNext = {1'b0, InA} - {1'b0, InB};
	wire [DiffW-1:0]     magNext = diffNext[DiffW-1] ? -diffNext : diffNext;
	wire                 overLimit = magNext > {1'b0, DiffLimit};  // equal is no alarm

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			seenA <= 1'b0;
			seenB <= 1'b0;
		end else if (bothSeen) begin
			seenA <= 1'b0;
			seenB <= 1'b0;
		end else begin
			seenA <= seenA | DoneA;
			seenB <= seenB | DoneB;
		end
	end

	// outputs hold until the next pair completes
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			DataA <= '0;
			DataB <= '0;
			Diff <= '0;
			Alarm <= 1'b0;
			SampleValid <= 1'b0;
		end else begin
			SampleValid <= bothSeen;
			if (bothSeen) begin
				DataA <= InA;
				DataB <= InB;
				Diff <= diffNext;
				Alarm <= overLimit;
			end
		end
	end

endmodule : pairCombiner

`default_nettype wire

/* design/adcDualCapture.sv */
`timescale 1ns/1ps
`default_nettype none

module adcDualCapture (
	input  wire                                 Clk,
	input  wire                                 Rst_n,
	input  wire                                 En_Conv,
	input  wire [adcCapturePkg::AdcChanW-1:0]   Channel,
	input  wire [adcCapturePkg::AdcDivW-1:0]    DivParam,
	input  wire [adcCapturePkg::AdcDataW-1:0]   DiffLimit,
	input  wire                                 DoutA,
	input  wire                                 DoutB,
	output wire                                 SclkA,
	output wire                                 CsNA,
	output wire                                 DinA,
	output wire                                 SclkB,
	output wire                                 CsNB,
	output wire                                 DinB,
	output wire [adcCapturePkg::AdcDataW-1:0]   DataA,
	output wire [adcCapturePkg::AdcDataW-1:0]   DataB,
	output wire [adcCapturePkg::DiffW-1:0]      Diff,
	output wire                                 Alarm,
	output wire                                 SampleValid,
	output wire                                 Busy
);

	import adcCapturePkg::*;

	wire [AdcDataW-1:0] rawA;  // controller results before pairing
	wire [AdcDataW-1:0] rawB;
	wire                doneA;
	wire                doneB;
	wire                busyA;
	wire                busyB;

	// both converters start on the same pulse and channel
	adcSerialCtrl u_adcA (
		.Clk       (Clk),
		.Rst_n     (Rst_n),
		.En_Conv   (En_Conv),
		.Channel   (Channel),
		.DivParam  (DivParam),
		.Dout      (DoutA),
		.Sclk      (SclkA),
		.CsN       (CsNA),
		.Din       (DinA),
		.Data      (rawA),
		.Conv_Done (doneA),
		.Busy      (busyA)
	);

	adcSerialCtrl u_adcB (
		.Clk       (Clk),
		.Rst_n     (Rst_n),
		.En_Conv   (En_Conv),
		.Channel   (Channel),
		.DivParam  (DivParam),
		.Dout      (DoutB),
		.Sclk      (SclkB),
		.CsN       (CsNB),
		.Din       (DinB),
		.Data      (rawB),
		.Conv_Done (doneB),
		.Busy      (busyB)
	);

	pairCombiner u_comb (
		.Clk         (Clk),
		.Rst_n       (Rst_n),
		.InA         (rawA),
		.InB         (rawB),
		.DoneA       (doneA),
		.DoneB       (doneB),
		.DiffLimit   (DiffLimit),
		.DataA       (DataA),
		.DataB       (DataB),
		.Diff        (Diff),
		.Alarm       (Alarm),
		.SampleValid (SampleValid)
	);

	assign Busy = busyA | busyB;  // either side still in its frame

endmodule : adcDualCapture

`default_nettype wire

/* dv/adcDualCapture_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module serialPinChecks (
	input wire Clk,
	input wire Rst_n,
	input wire Sclk,
	input wire CsN,
	input wire Conv_Done
);

	property sclkHighWhileDeselected;
		@(posedge Clk) disable iff (!Rst_n) CsN |-> Sclk;  // clock parks high between frames
	endproperty

	property doneSingleCycle;
		@(posedge Clk) disable iff (!Rst_n) Conv_Done |=> !Conv_Done;
	endproperty

	property csHighAtResetRelease;
		@(posedge Clk) $rose(Rst_n) |-> CsN;
	endproperty

	sclkIdle: assert property (sclkHighWhileDeselected)
		else $error("SCLK is low while CS_N is high");
	donePulse: assert property (doneSingleCycle)
		else $error("Conv_Done stayed high for more than one cycle");
	csReset: assert property (csHighAtResetRelease)
		else $error("CS_N is low when reset is released");

endmodule : serialPinChecks

bind adcSerialCtrl serialPinChecks u_pinChecks (.Clk(Clk), .Rst_n(Rst_n), .Sclk(Sclk),
	.CsN(CsN), .Conv_Done(Conv_Done));

`default_nettype wire

/* dv/adcDualCapture_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// serial ADC, answers with the channel addressed in the previous frame
module serialAdcModel (
	input  wire                                  Sclk,
	input  wire                                  CsN,
	input  wire                                  Din,
	input  wire [8*adcCapturePkg::AdcDataW-1:0]  Values,
	output wire                                  Dout
);

	import adcCapturePkg::*;

	logic [AdcChanW-1:0]  nextChan = '0;  // channel 0 for the first frame
	logic [AdcChanW-1:0]  addrBits = '0;
	logic [AdcDataW-1:0]  word = '0;
	logic                 doutReg = 1'b0;
	logic                 lastSclk = 1'b1;
	logic                 lastCsN = 1'b1;
	int                   falls = 0;
	int                   rises = 0;

	assign Dout = doutReg;

	always @(Sclk or CsN) begin
		if (lastCsN === 1'b1 && CsN === 1'b0) begin
			word = Values[int'(nextChan)*AdcDataW +: AdcDataW];
			falls = 0;
			rises = 0;
			doutReg = 1'b0;
		end else if (lastCsN === 1'b0 && CsN === 1'b1) begin
			nextChan = addrBits;  // applies to the next frame
		end else if (CsN === 1'b0 && lastSclk === 1'b1 && Sclk === 1'b0) begin
			falls++;
			// four leading zeros, then msb first
			doutReg = (falls > 4 && falls <= AdcDataW + 4) ? word[AdcDataW + 4 - falls] : 1'b0;
		end else if (CsN === 1'b0 && lastSclk === 1'b0 && Sclk === 1'b1) begin
			rises++;
			if (rises >= 3 && rises <= 5)
				addrBits = {addrBits[AdcChanW-2:0], Din};  // addr msb first
		end
		lastSclk = Sclk;
		lastCsN = CsN;
	end

endmodule : serialAdcModel

module adcDualCapture_tb;

	import adcCapturePkg::*;

	localparam int NumChanConv = 8;
	localparam int NumDiffConv = 6;
	localparam int NumDivConv = 6;
	localparam int NumBusyConv = 2;
	localparam int NumStreamConv = 40;
	localparam int TotalConv = NumChanConv + NumDiffConv + NumDivConv + NumBusyConv + NumStreamConv;
	localparam int TimeoutCycles = TotalConv * 40 * 255 + 2000;  // slowest divider plus margin

	logic Clk;
	logic Rst_n;
	logic En_Conv;
	logic [AdcChanW-1:0] Channel;
	logic [AdcDivW-1:0] DivParam;
	logic [AdcDataW-1:0] DiffLimit;
	wire DoutA, DoutB, SclkA, CsNA, DinA, SclkB, CsNB, DinB;
	wire [AdcDataW-1:0] DataA, DataB;
	wire [DiffW-1:0] Diff;
	wire Alarm, SampleValid, Busy;

	logic [8*AdcDataW-1:0] tableA;  // one 12-bit value per channel
	logic [8*AdcDataW-1:0] tableB;
	logic [31:0] rnd;
	logic [AdcChanW-1:0] prevChan;  // address sent in the last frame
	logic [AdcChanW-1:0] pendingChan;
	logic [AdcDataW-1:0] curLimit;
	int seed = 91;
	int validCount = 0;
	int startCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int testCount = 0;
	int failCount = 0;

	adcDualCapture u_dut (
		.Clk(Clk), .Rst_n(Rst_n), .En_Conv(En_Conv), .Channel(Channel), .DivParam(DivParam),
		.DiffLimit(DiffLimit), .DoutA(DoutA), .DoutB(DoutB), .SclkA(SclkA), .CsNA(CsNA),
		.DinA(DinA), .SclkB(SclkB), .CsNB(CsNB), .DinB(DinB), .DataA(DataA), .DataB(DataB),
		.Diff(Diff), .Alarm(Alarm), .SampleValid(SampleValid), .Busy(Busy)
	);

	serialAdcModel u_modelA (.Sclk(SclkA), .CsN(CsNA), .Din(DinA), .Values(tableA), .Dout(DoutA));
	serialAdcModel u_modelB (.Sclk(SclkB), .CsN(CsNB), .Din(DinB), .Values(tableB), .Dout(DoutB));

	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	always @(posedge Clk) begin
		if (SampleValid === 1'b1)
			validCount <= validCount + 1;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TimeoutCycles) begin
			@(posedge Clk);
			cycles++;
		end
		$display("Timeout: tests did not finish within %0d clock cycles", TimeoutCycles);
		$display("=== FAIL ===");
		$finish;
	end

	function automatic logic [AdcDataW-1:0] entryOf(input logic [8*AdcDataW-1:0] tbl,
			input logic [AdcChanW-1:0] ch);
		return tbl[int'(ch)*AdcDataW +: AdcDataW];
	endfunction

	function automatic int pairDifference(input logic [AdcChanW-1:0] ch);
		return int'(entryOf(tableA, ch)) - int'(entryOf(tableB, ch));
	endfunction

	task automatic checkValue(input string testName, input string what, input int expected,
			input int actual);
		checkCount++;
		assert (expected == actual) else begin
			$display("Error %s %s: expected 0x%0h actual 0x%0h", testName, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic finishTest(input string testName, input int errAtStart);
		testCount++;
		if (errorCount > errAtStart) begin
			failCount++;
			$display("test %s: FAILED with %0d errors", testName, errorCount - errAtStart);
		end else begin
			$display("test %s: passed", testName);
		end
	endtask

	task automatic fillTables();
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			tableA[i*AdcDataW +: AdcDataW] = rnd[AdcDataW-1:0];
			tableB[i*AdcDataW +: AdcDataW] = rnd[AdcDataW+15:16];
		end
	endtask

	task automatic startConversion(input logic [AdcChanW-1:0] ch, input logic [AdcDivW-1:0] div,
			input logic [AdcDataW-1:0] limit);
		while (Busy !== 1'b0)
			@(negedge Clk);
		@(posedge Clk);
		Channel <= ch;
		DivParam <= div;
		DiffLimit <= limit;
		En_Conv <= 1'b1;
		curLimit = limit;
		pendingChan = ch;
		startCount = validCount;
		@(posedge Clk);
		En_Conv <= 1'b0;
	endtask

	task automatic awaitResult(input string testName);
		int d;
		int mag;
		d = pairDifference(prevChan);
		mag = (d < 0) ? -d : d;
		do begin
			@(negedge Clk);
		end while (SampleValid !== 1'b1);
		checkValue(testName, "DataA", int'(entryOf(tableA, prevChan)), int'(DataA));
		checkValue(testName, "DataB", int'(entryOf(tableB, prevChan)), int'(DataB));
		checkValue(testName, "Diff", d & ((1 << DiffW) - 1), int'(Diff));
		checkValue(testName, "Alarm", (mag > int'(curLimit)) ? 1 : 0, int'(Alarm));
		repeat (2) @(negedge Clk);
		checkValue(testName, "SampleValid pulses", 1, validCount - startCount);
		prevChan = pendingChan;
	endtask

	task automatic convert(input string testName, input logic [AdcChanW-1:0] ch,
			input logic [AdcDivW-1:0] div, input logic [AdcDataW-1:0] limit);
		startConversion(ch, div, limit);
		awaitResult(testName);
	endtask

	initial begin
		int errAtStart;
		int mag;
		logic [AdcChanW-1:0] chX;
		logic [AdcDataW-1:0] lim;
		Rst_n = 1'b0;
		En_Conv = 1'b0;
		Channel = '0;
		DivParam = AdcDivW'(2);
		DiffLimit = '0;
		prevChan = '0;
		pendingChan = '0;
		curLimit = '0;
		fillTables();
		repeat (5) @(posedge Clk);
		Rst_n <= 1'b1;

		errAtStart = errorCount;
		@(negedge Clk);
		checkValue("resetState", "CsNA CsNB SclkA SclkB", 15, int'({CsNA, CsNB, SclkA, SclkB}));
		checkValue("resetState", "SampleValid Alarm Busy", 0, int'({SampleValid, Alarm, Busy}));
		checkValue("resetState", "DataA", 0, int'(DataA));
		checkValue("resetState", "DataB", 0, int'(DataB));
		checkValue("resetState", "Diff", 0, int'(Diff));
		finishTest("resetState", errAtStart);

		errAtStart = errorCount;
		for (int ch = 0; ch < NumChanConv; ch++)
			convert("channelDecode", AdcChanW'(ch), AdcDivW'(2), '1);
		finishTest("channelDecode", errAtStart);

		// first two limits sit exactly at and just under the magnitude
		errAtStart = errorCount;
		for (int k = 0; k < NumDiffConv; k++) begin
			fillTables();
			mag = pairDifference(prevChan);
			mag = (mag < 0) ? -mag : mag;
			rnd = $random(seed);
			if (k == 0)
				lim = AdcDataW'(mag);
			else if (k == 1 && mag > 0)
				lim = AdcDataW'(mag - 1);
			else
				lim = {1'b0, rnd[AdcDataW-2:0]};
			convert("diffAlarm", rnd[31:29], AdcDivW'(2), lim);
		end
		finishTest("diffAlarm", errAtStart);

		errAtStart = errorCount;
		for (int k = 0; k < NumDivConv; k++) begin
			rnd = $random(seed);
			convert("dividerValues", rnd[31:29], (k == 0) ? AdcDivW'(255) :
				AdcDivW'(32'd2 + rnd % 32'd254), rnd[AdcDataW-1:0]);
		end
		finishTest("dividerValues", errAtStart);

		// second start mid-frame on another channel must be dropped
		errAtStart = errorCount;
		rnd = $random(seed);
		chX = rnd[AdcChanW-1:0];
		startConversion(chX, AdcDivW'(5), '1);
		while (CsNA !== 1'b0)
			@(negedge Clk);
		checkValue("startWhileBusy", "Busy at second start", 1, int'(Busy));
		@(posedge Clk);
		Channel <= chX + 3'd3;
		En_Conv <= 1'b1;
		@(posedge Clk);
		En_Conv <= 1'b0;
		awaitResult("startWhileBusy");
		convert("startWhileBusy", chX + 3'd1, AdcDivW'(5), '1);  // returns chX data
		finishTest("startWhileBusy", errAtStart);

		errAtStart = errorCount;
		for (int k = 0; k < NumStreamConv; k++) begin
			rnd = $random(seed);
			convert("randomStream", rnd[31:29], AdcDivW'(32'd2 + rnd[15:0] % 32'd254),
				rnd[27:16]);
		end
		finishTest("randomStream", errAtStart);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, failCount, checkCount, errorCount);
		if (failCount == 0 && errorCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule : adcDualCapture_tb

`default_nettype wire

/* adcDualCapture.f */
design/adcCapturePkg.sv
design/adcSerialCtrl.sv
design/pairCombiner.sv
design/adcDualCapture.sv
dv/adcDualCapture_assertions.sv
dv/adcDualCapture_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= adcDualCapture_tb
FILELIST ?= adcDualCapture.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= === PASS ===

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
